/* src/core_settings.svh */
// data path is fixed at 32 bits and the PC width also limits the data address range
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ----------------------------------------
// data path
// ----------------------------------------
`define CORE_XLEN 32
`define CORE_REG_W 5

// ----------------------------------------
// addressing
// ----------------------------------------
// byte address over a 64 KiB space
`define CORE_PC_W 16
`define CORE_RESET_PC 16'h0000

`endif

/* src/isa_pkg.sv */
// covers only the RV32I subset this core executes and maps every other opcode to op_illegal
package isa_pkg;

	// major opcodes in instr[6:0]
	typedef enum logic [6:0] {
		op_illegal = 7'b0000000,
		op_load    = 7'b0000011,
		op_imm     = 7'b0010011,
		op_store   = 7'b0100011,
		op_reg     = 7'b0110011,
		op_branch  = 7'b1100011,
		op_jal     = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	// all zero is a bubble
	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src_imm;
		logic    branch;
		logic    branch_ne;
		logic    jump;
		alu_op_t alu_op;
	} ctrl_t;

endpackage

/* src/pipe_pkg.sv */
// stage registers carry no valid bit past IF/ID so a bubble is an all-zero ctrl field
`include "core_settings.svh"

package pipe_pkg;

	// ----------------------------------------
	// stage registers
	// ----------------------------------------
	typedef struct packed {
		logic                   valid;
		logic [`CORE_PC_W-1:0]  pc;
		logic [`CORE_XLEN-1:0]  instr;
	} if_id_t;

	typedef struct packed {
		isa_pkg::ctrl_t         ctrl;
		logic [`CORE_PC_W-1:0]  pc;
		logic [`CORE_XLEN-1:0]  rs1_val;
		logic [`CORE_XLEN-1:0]  rs2_val;
		logic [`CORE_XLEN-1:0]  imm;
		logic [`CORE_REG_W-1:0] rs1;
		logic [`CORE_REG_W-1:0] rs2;
		logic [`CORE_REG_W-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		isa_pkg::ctrl_t         ctrl;
		logic [`CORE_XLEN-1:0]  alu_result;
		logic [`CORE_XLEN-1:0]  store_data;
		logic [`CORE_REG_W-1:0] rd;
		logic [`CORE_XLEN-1:0]  link;
	} ex_mem_t;

	typedef struct packed {
		logic                   reg_write;
		logic [`CORE_REG_W-1:0] rd;
		logic [`CORE_XLEN-1:0]  value;
	} mem_wb_t;

	// ----------------------------------------
	// data port
	// ----------------------------------------
	// word address held until ready
	typedef struct packed {
		logic                    valid;
		logic                    we;
		logic [`CORE_PC_W-3:0]   addr;
		logic [`CORE_XLEN-1:0]   wdata;
	} dmem_req_t;

	typedef enum logic [1:0] {
		mem_idle,
		mem_wait,
		mem_done
	} dmem_state_t;

endpackage

/* src/pc_counter.sv */
// hold wins over redirect so a held branch must stay in execute until the hold drops
`include "core_settings.svh"

module pc_counter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  hold,
	input  logic                  redirect,
	input  logic [`CORE_PC_W-1:0] target,
	output logic [`CORE_PC_W-1:0] pc
);

	logic [`CORE_PC_W-1:0] pc_next;

	// sequential fetch unless execute redirects
	assign pc_next = redirect ? target : pc + `CORE_PC_W'(4);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `CORE_RESET_PC;
		end else if (!hold) begin
			pc <= pc_next;
		end
	end

endmodule

/* src/decode_unit.sv */
// decodes ADD SUB AND OR SLT ADDI LW SW BEQ BNE JAL only and turns anything else into a bubble
`include "core_settings.svh"

module decode_unit (
	input  logic [`CORE_XLEN-1:0]  instr,
	output isa_pkg::ctrl_t         ctrl,
	output logic [`CORE_REG_W-1:0] rs1,
	output logic [`CORE_REG_W-1:0] rs2,
	output logic [`CORE_REG_W-1:0] rd,
	output logic [`CORE_XLEN-1:0]  imm
);

	isa_pkg::opcode_t opcode;
	logic [2:0]       funct3;
	logic             funct7_b5;

	assign funct3    = instr[14:12];
	assign funct7_b5 = instr[30];
	assign rs1       = instr[19:15];
	assign rs2       = instr[24:20];
	assign rd        = instr[11:7];

	always_comb begin
		case (instr[6:0])
			isa_pkg::op_reg, isa_pkg::op_imm, isa_pkg::op_load,
			isa_pkg::op_store, isa_pkg::op_branch, isa_pkg::op_jal:
				opcode = isa_pkg::opcode_t'(instr[6:0]);
			default:
				opcode = isa_pkg::op_illegal;
		endcase
	end

	// ----------------------------------------
	// control bits
	// ----------------------------------------
	always_comb begin
		ctrl = '0;
		case (opcode)
			isa_pkg::op_reg: begin
				ctrl.reg_write = 1'b1;
				case (funct3)
					3'b000: ctrl.alu_op = funct7_b5 ? isa_pkg::alu_sub : isa_pkg::alu_add;
					3'b010: ctrl.alu_op = isa_pkg::alu_slt;
					3'b110: ctrl.alu_op = isa_pkg::alu_or;
					3'b111: ctrl.alu_op = isa_pkg::alu_and;
					default: ctrl = '0;
				endcase
			end
			isa_pkg::op_imm: begin
				// ADDI only
				ctrl.reg_write   = (funct3 == 3'b000);
				ctrl.alu_src_imm = (funct3 == 3'b000);
			end
			isa_pkg::op_load: begin
				ctrl.reg_write   = (funct3 == 3'b010);
				ctrl.mem_read    = (funct3 == 3'b010);
				ctrl.mem_to_reg  = (funct3 == 3'b010);
				ctrl.alu_src_imm = (funct3 == 3'b010);
			end
			isa_pkg::op_store: begin
				ctrl.mem_write   = (funct3 == 3'b010);
				ctrl.alu_src_imm = (funct3 == 3'b010);
			end
			isa_pkg::op_branch: begin
				// funct3 bit 0 tells BNE from BEQ
				ctrl.branch    = (funct3[2:1] == 2'b00);
				ctrl.branch_ne = (funct3 == 3'b001);
			end
			isa_pkg::op_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump      = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	// ----------------------------------------
	// immediates
	// ----------------------------------------
	always_comb begin
		case (opcode)
			isa_pkg::op_store:
				imm = {{(`CORE_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
			isa_pkg::op_branch:
				imm = {{(`CORE_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			isa_pkg::op_jal:
				imm = {{(`CORE_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				imm = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

/* src/reg_file.sv */
// x0 reads as zero and writes are ignored while reset is low
`include "core_settings.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   we,
	input  logic [`CORE_REG_W-1:0] waddr,
	input  logic [`CORE_XLEN-1:0]  wdata,
	input  logic [`CORE_REG_W-1:0] raddr1,
	input  logic [`CORE_REG_W-1:0] raddr2,
	output logic [`CORE_XLEN-1:0]  rdata1,
	output logic [`CORE_XLEN-1:0]  rdata2
);

	logic [`CORE_XLEN-1:0] regs [1:(1 << `CORE_REG_W)-1];
	logic                  write_en;

	assign write_en = we && rst_n && (waddr != '0);

	always_ff @(posedge clk) begin
		if (write_en) begin
			regs[waddr] <= wdata;
		end
	end

	// decode sees the value retiring this cycle
	function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (write_en && addr == waddr)
			return wdata;
		return regs[addr];
	endfunction

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule

/* src/hazard_unit.sv */
// forwarding select is 00 for the register value, 01 for the memory stage and 10 for writeback
`include "core_settings.svh"

module hazard_unit (
	input  logic [`CORE_REG_W-1:0] id_rs1,
	input  logic [`CORE_REG_W-1:0] id_rs2,
	input  pipe_pkg::id_ex_t       ex_stage,
	input  pipe_pkg::ex_mem_t      mem_stage,
	input  pipe_pkg::mem_wb_t      wb_stage,
	input  logic                   redirect,
	output logic [1:0]             fwd_a,
	output logic [1:0]             fwd_b,
	output logic                   load_stall,
	output logic                   flush
);

	// younger producer first
	function automatic logic [1:0] fwd_sel(input logic [`CORE_REG_W-1:0] src);
		if (src == '0)
			return 2'b00;
		if (mem_stage.ctrl.reg_write && mem_stage.rd == src)
			return 2'b01;
		if (wb_stage.reg_write && wb_stage.rd == src)
			return 2'b10;
		return 2'b00;
	endfunction

	always_comb begin
		fwd_a = fwd_sel(ex_stage.rs1);
		fwd_b = fwd_sel(ex_stage.rs2);
	end

	// load result is not ready for the instruction right behind it
	assign load_stall = ex_stage.ctrl.mem_read && (ex_stage.rd != '0) &&
			((ex_stage.rd == id_rs1) || (ex_stage.rd == id_rs2));

	// taken branch or jump kills IF/ID and ID/EX
	assign flush = redirect;

endmodule

/* src/exec_unit.sv */
// branch target is pc plus immediate and only the low PC width bits of it are kept
`include "core_settings.svh"

module exec_unit (
	input  pipe_pkg::id_ex_t      ex_stage,
	input  logic [1:0]            fwd_a,
	input  logic [1:0]            fwd_b,
	input  logic [`CORE_XLEN-1:0] mem_value,
	input  logic [`CORE_XLEN-1:0] wb_value,
	output pipe_pkg::ex_mem_t     result,
	output logic                  redirect,
	output logic [`CORE_PC_W-1:0] target
);

	logic [`CORE_XLEN-1:0] op_a;
	logic [`CORE_XLEN-1:0] op_b_reg;
	logic [`CORE_XLEN-1:0] op_b;
	logic [`CORE_XLEN-1:0] alu_out;
	logic [`CORE_PC_W-1:0] pc_plus4;
	logic                  taken;

	function automatic logic [`CORE_XLEN-1:0] pick(input logic [1:0] sel,
			input logic [`CORE_XLEN-1:0] reg_val);
		case (sel)
			2'b01: return mem_value;
			2'b10: return wb_value;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		op_a     = pick(fwd_a, ex_stage.rs1_val);
		op_b_reg = pick(fwd_b, ex_stage.rs2_val);
	end

	assign op_b = ex_stage.ctrl.alu_src_imm ? ex_stage.imm : op_b_reg;

	always_comb begin
		case (ex_stage.ctrl.alu_op)
			isa_pkg::alu_sub: alu_out = op_a - op_b;
			isa_pkg::alu_and: alu_out = op_a & op_b;
			isa_pkg::alu_or:  alu_out = op_a | op_b;
			isa_pkg::alu_slt: alu_out = `CORE_XLEN'($signed(op_a) < $signed(op_b));
			default:          alu_out = op_a + op_b;
		endcase
	end

	// BEQ or BNE on register equality
	assign taken    = ex_stage.ctrl.branch && ((op_a == op_b_reg) != ex_stage.ctrl.branch_ne);
	assign redirect = taken || ex_stage.ctrl.jump;
	assign target   = ex_stage.pc + ex_stage.imm[`CORE_PC_W-1:0];
	assign pc_plus4 = ex_stage.pc + `CORE_PC_W'(4);

	always_comb begin
		result.ctrl       = ex_stage.ctrl;
		result.alu_result = alu_out;
		result.store_data = op_b_reg;
		result.rd         = ex_stage.rd;
		result.link       = `CORE_XLEN'(pc_plus4);
	end

endmodule

/* src/dmem_fsm.sv */
// one request per LW or SW and the request fields follow the held memory stage
`include "core_settings.svh"

module dmem_fsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  pipe_pkg::ex_mem_t     mem_stage,
	output pipe_pkg::dmem_req_t   dmem_req,
	input  logic [`CORE_XLEN-1:0] dmem_rdata,
	input  logic                  dmem_ready,
	output logic                  mem_stall,
	output logic [`CORE_XLEN-1:0] load_data
);

	pipe_pkg::dmem_state_t state;
	logic                  mem_op;

	assign mem_op = mem_stage.ctrl.mem_read || mem_stage.ctrl.mem_write;

	// idle -> wait -> done -> idle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= pipe_pkg::mem_idle;
		end else begin
			case (state)
				pipe_pkg::mem_idle: if (mem_op) state <= pipe_pkg::mem_wait;
				pipe_pkg::mem_wait: if (dmem_ready) state <= pipe_pkg::mem_done;
				default: state <= pipe_pkg::mem_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == pipe_pkg::mem_wait && dmem_ready) begin
			load_data <= dmem_rdata;
		end
	end

	// released in done so the instruction leaves at that edge
	assign mem_stall = (state == pipe_pkg::mem_idle && mem_op) || (state == pipe_pkg::mem_wait);

	always_comb begin
		dmem_req.valid = (state == pipe_pkg::mem_wait);
		dmem_req.we    = mem_stage.ctrl.mem_write;
		dmem_req.addr  = mem_stage.alu_result[`CORE_PC_W-1:2];
		dmem_req.wdata = mem_stage.store_data;
	end

endmodule

/* src/rv_core.sv */
// five-stage RV32I subset core without JALR or compressed instructions on little-endian word ports
`include "core_settings.svh"

module rv_core (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic [`CORE_PC_W-3:0] imem_addr,
	input  logic [`CORE_XLEN-1:0] imem_rdata,
	output pipe_pkg::dmem_req_t   dmem_req,
	input  logic [`CORE_XLEN-1:0] dmem_rdata,
	input  logic                  dmem_ready
);

	logic [`CORE_PC_W-1:0]  pc;
	logic [`CORE_PC_W-1:0]  target;
	logic                   redirect;
	logic                   flush;
	logic                   load_stall;
	logic                   mem_stall;
	logic                   pc_hold;
	isa_pkg::ctrl_t         dec_ctrl;
	logic [`CORE_REG_W-1:0] dec_rs1;
	logic [`CORE_REG_W-1:0] dec_rs2;
	logic [`CORE_REG_W-1:0] dec_rd;
	logic [`CORE_XLEN-1:0]  dec_imm;
	logic [`CORE_XLEN-1:0]  rs1_val;
	logic [`CORE_XLEN-1:0]  rs2_val;
	logic [`CORE_XLEN-1:0]  mem_value;
	logic [`CORE_XLEN-1:0]  load_data;
	logic [1:0]             fwd_a;
	logic [1:0]             fwd_b;
	pipe_pkg::if_id_t       if_id;
	pipe_pkg::id_ex_t       id_ex;
	pipe_pkg::id_ex_t       id_next;
	pipe_pkg::ex_mem_t      ex_mem;
	pipe_pkg::ex_mem_t      ex_next;
	pipe_pkg::mem_wb_t      mem_wb;

	assign pc_hold   = mem_stall || load_stall;
	assign imem_addr = pc[`CORE_PC_W-1:2];

	pc_counter u_pc (.clk(clk), .rst_n(rst_n), .hold(pc_hold), .redirect(redirect),
			.target(target), .pc(pc));

	decode_unit u_dec (.instr(if_id.instr), .ctrl(dec_ctrl), .rs1(dec_rs1), .rs2(dec_rs2),
			.rd(dec_rd), .imm(dec_imm));

	reg_file u_rf (.clk(clk), .rst_n(rst_n), .we(mem_wb.reg_write), .waddr(mem_wb.rd),
			.wdata(mem_wb.value), .raddr1(dec_rs1), .raddr2(dec_rs2),
			.rdata1(rs1_val), .rdata2(rs2_val));

	hazard_unit u_haz (.id_rs1(dec_rs1), .id_rs2(dec_rs2), .ex_stage(id_ex),
			.mem_stage(ex_mem), .wb_stage(mem_wb), .redirect(redirect), .fwd_a(fwd_a),
			.fwd_b(fwd_b), .load_stall(load_stall), .flush(flush));

	exec_unit u_ex (.ex_stage(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_value(mem_value),
			.wb_value(mem_wb.value), .result(ex_next), .redirect(redirect), .target(target));

	dmem_fsm u_dmem (.clk(clk), .rst_n(rst_n), .mem_stage(ex_mem), .dmem_req(dmem_req),
			.dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready), .mem_stall(mem_stall),
			.load_data(load_data));

	// ----------------------------------------
	// IF/ID and ID/EX
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if_id.valid <= 1'b0;
		end else if (!mem_stall) begin
			if (flush) begin
				if_id.valid <= 1'b0;
			end else if (!load_stall) begin
				if_id.valid <= 1'b1;
				if_id.pc    <= pc;
				if_id.instr <= imem_rdata;
			end
		end
	end

	always_comb begin
		id_next.ctrl    = if_id.valid ? dec_ctrl : '0;
		id_next.pc      = if_id.pc;
		id_next.rs1_val = rs1_val;
		id_next.rs2_val = rs2_val;
		id_next.imm     = dec_imm;
		id_next.rs1     = dec_rs1;
		id_next.rs2     = dec_rs2;
		id_next.rd      = dec_rd;
	end

	// bubble on flush or load-use
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.ctrl <= '0;
		end else if (!mem_stall) begin
			if (flush || load_stall)
				id_ex.ctrl <= '0;
			else
				id_ex <= id_next;
		end
	end

	// ----------------------------------------
	// EX/MEM and MEM/WB
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.ctrl <= '0;
		end else if (!mem_stall) begin
			ex_mem <= ex_next;
		end
	end

	assign mem_value = ex_mem.ctrl.jump ? ex_mem.link : ex_mem.alu_result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.reg_write <= 1'b0;
		end else if (!mem_stall) begin
			mem_wb.reg_write <= ex_mem.ctrl.reg_write;
			mem_wb.rd        <= ex_mem.rd;
			mem_wb.value     <= ex_mem.ctrl.mem_to_reg ? load_data : mem_value;
		end
	end

endmodule

/* tests/tb_core.sv */
// memory models cover 64 program words and 256 data words; stores outside them alias
`include "core_settings.svh"

module tb_core;

	localparam int STORE_TIMEOUT = 400;
	localparam int QUIET_CYCLES  = 60;

	logic                  clk;
	logic                  rst_n;
	logic [`CORE_PC_W-3:0] imem_addr;
	logic [`CORE_XLEN-1:0] imem_rdata;
	pipe_pkg::dmem_req_t   dmem_req;
	logic [`CORE_XLEN-1:0] dmem_rdata;
	logic                  dmem_ready;

	logic [31:0]           stim [0:127];
	logic [`CORE_XLEN-1:0] imem [0:63];
	logic [`CORE_XLEN-1:0] dmem [0:255];
	logic [`CORE_PC_W-3:0] exp_addr [$];
	logic [`CORE_XLEN-1:0] exp_data [$];
	logic [`CORE_PC_W-3:0] obs_addr [$];
	logic [`CORE_XLEN-1:0] obs_data [$];

	int                    err_value;
	int                    err_protocol;
	int                    err_timeout;
	logic [31:0]           rng;
	logic                  mem_active;
	logic [1:0]            mem_wait;
	logic                  req_held;
	pipe_pkg::dmem_req_t   req_cap;

	rv_core u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata),
		.dmem_ready(dmem_ready)
	);

	always #4 clk = ~clk;

	assign imem_rdata = (imem_addr < 64) ? imem[imem_addr[5:0]] : '0;

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_store_addr(input string name, input logic [`CORE_PC_W-3:0] exp_v,
			input logic [`CORE_PC_W-3:0] act_v);
		if (exp_v !== act_v) begin
			err_value++;
			$display("Fail at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_store_data(input string name, input logic [`CORE_XLEN-1:0] exp_v,
			input logic [`CORE_XLEN-1:0] act_v);
		if (exp_v !== act_v) begin
			err_value++;
			$display("Fail at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_req_kind(input string name, input logic exp_v, input logic act_v);
		if (exp_v !== act_v) begin
			err_value++;
			$display("Fail at %0t: %s expected %b actual %b", $time, name, exp_v, act_v);
		end
	endtask

	// ----------------------------------------
	// data memory with random ready delay
	// ----------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			dmem_ready <= 1'b0;
			mem_active <= 1'b0;
		end else if (dmem_ready) begin
			dmem_ready <= 1'b0;
		end else if (dmem_req.valid) begin
			if (!mem_active && rng[17:16] != 2'd0) begin
				mem_active <= 1'b1;
				mem_wait   <= rng[17:16] - 2'd1;
				rng        <= next_rand(rng);
			end else if (!mem_active || mem_wait == 2'd0) begin
				// accept now and raise ready for the next cycle
				if (!mem_active)
					rng <= next_rand(rng);
				mem_active <= 1'b0;
				dmem_ready <= 1'b1;
				if (dmem_req.we)
					dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
				else
					dmem_rdata <= dmem[dmem_req.addr[7:0]];
			end else begin
				mem_wait <= mem_wait - 2'd1;
			end
		end
	end

	// request held stable until ready and stores logged at ready
	always @(posedge clk) begin
		if (!rst_n) begin
			req_held <= 1'b0;
		end else if (dmem_req.valid) begin
			if (!req_held) begin
				req_held <= 1'b1;
				req_cap  <= dmem_req;
			end else begin
				check_req_kind("dmem_req.we", req_cap.we, dmem_req.we);
				check_store_addr("dmem_req.addr", req_cap.addr, dmem_req.addr);
				if (dmem_req.we)
					check_store_data("dmem_req.wdata", req_cap.wdata, dmem_req.wdata);
			end
			if (dmem_ready) begin
				req_held <= 1'b0;
				if (dmem_req.we) begin
					obs_addr.push_back(dmem_req.addr);
					obs_data.push_back(dmem_req.wdata);
				end
			end
		end
	end

	initial begin
		int n;
		int cycles;
		logic timed_out;

		clk          = 1'b0;
		rst_n        = 1'b0;
		dmem_ready   = 1'b0;
		dmem_rdata   = '0;
		err_value    = 0;
		err_protocol = 0;
		err_timeout  = 0;
		rng          = 32'h194f_4ca2;
		mem_active   = 1'b0;
		mem_wait     = '0;
		req_held     = 1'b0;
		timed_out    = 1'b0;

		for (int i = 0; i < 128; i++)
			stim[i] = '0;
		$readmemh("tests/core_stim.txt", stim);
		for (int i = 0; i < 64; i++)
			imem[i] = stim[i];
		for (int i = 0; i < 256; i++)
			dmem[i] = 32'hdead_0000 | (i * 32'h0001_0101);
		n = stim[64];
		for (int j = 0; j < n; j++)
			dmem[stim[65 + 2 * j][7:0]] = stim[66 + 2 * j];
		n = stim[96];
		for (int j = 0; j < n; j++) begin
			exp_addr.push_back(stim[97 + 2 * j][`CORE_PC_W-3:0]);
			exp_data.push_back(stim[98 + 2 * j]);
		end

		// ----------------------------------------
		// reset
		// ----------------------------------------
		for (int k = 0; k < 4; k++) begin
			@(posedge clk);
			if (k == 3)
				rst_n <= 1'b1;
			@(negedge clk);
			check_req_kind("dmem_req.valid", 1'b0, dmem_req.valid);
			check_store_addr("imem_addr", '0, imem_addr);
		end

		// ----------------------------------------
		// stores in program order
		// ----------------------------------------
		for (int i = 0; i < exp_addr.size() && !timed_out; i++) begin
			cycles = 0;
			while (obs_addr.size() <= i && cycles < STORE_TIMEOUT) begin
				@(negedge clk);
				cycles++;
			end
			if (obs_addr.size() <= i) begin
				err_timeout++;
				timed_out = 1'b1;
				$display("timeout while waiting for store number %0d", i);
			end else begin
				check_store_addr("dmem_req.addr", exp_addr[i], obs_addr[i]);
				check_store_data("dmem_req.wdata", exp_data[i], obs_data[i]);
			end
		end

		// the program spins on its last jump and makes no more stores
		cycles = 0;
		while (!timed_out && cycles < QUIET_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (obs_addr.size() > exp_addr.size()) begin
			err_protocol++;
			$display("core made %0d stores but only %0d were expected",
					obs_addr.size(), exp_addr.size());
		end

		$display("errors: value %0d, protocol %0d, timeout %0d",
				err_value, err_protocol, err_timeout);
		if (err_value == 0 && err_protocol == 0 && err_timeout == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/pc_counter.sv
src/decode_unit.sv
src/reg_file.sv
src/hazard_unit.sv
src/exec_unit.sv
src/dmem_fsm.sv
src/rv_core.sv
tests/tb_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f sources.f --top-module tb_core --Mdir obj_dir -o sim_core
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi

exit 0

/* tests/core_stim.txt */
// @00 program words, @40 data word count then (word address, value) pairs,
// @60 expected store count then (word address, value) pairs in store order
@00
00600093 00708113 002081B3 40118233
0041F2B3 00326333 003223B3 00302023
00402223 00502423 00602623 00702823
04002403 001404B3 00902A23 00208463
00102C23 00209663 00202E23 00302E23
00728463 00402E23 00729463 00602E23
00C0056F 02102023 02202023 02A02023
0000006F
@40
00000001
00000010 00000100
@60
00000009
00000000 00000013 00000001 0000000D 00000002 00000001
00000003 0000001F 00000004 00000001 00000005 00000106
00000006 00000006 00000007 0000001F 00000008 00000064
